// ==== hdl/matrix_pkg.sv ====
package matrix_pkg;

    // Matrix geometry
    localparam int mat_dim    = 16;
    localparam int mat_idx_w  = $clog2(mat_dim);
    localparam int mem_words  = mat_dim * mat_dim;
    localparam int mem_addr_w = 2 * mat_idx_w;   // Row index then column index

    // Data widths
    localparam int elem_w      = 16;
    localparam int result_w    = 48;
    localparam int multi_count = 3;              // Elements per multi fetch

    // Request mode bits
    localparam logic mode_single = 1'b0;
    localparam logic mode_multi  = 1'b1;
    localparam logic dir_horiz   = 1'b0;         // Walk along the row
    localparam logic dir_vert    = 1'b1;         // Walk down the column

    typedef struct packed {
        logic [15:0] row;
        logic [15:0] col;
    } matrix_rc_t;

    // Address word, either flat or split into row and column
    typedef union packed {
        logic [31:0] word;
        matrix_rc_t  rc;
    } matrix_addr_u;

endpackage

// ==== hdl/matrix_mem.sv ====
module matrix_mem import matrix_pkg::*; (
    input  logic                  CLK,
    input  logic                  wr_en,
    input  matrix_addr_u          wr_addr,
    input  logic [elem_w-1:0]     wr_data,
    input  logic                  rd_en,
    input  logic [mem_addr_w-1:0] rd_addr,
    output logic [elem_w-1:0]     rd_data
);

    logic [elem_w-1:0]     mem [mem_words];
    logic [mem_addr_w-1:0] wr_word;

    // Only the low index bits address the array
    assign wr_word = {wr_addr.rc.row[mat_idx_w-1:0], wr_addr.rc.col[mat_idx_w-1:0]};

    always_ff @(posedge CLK) begin
        if (wr_en) begin
            mem[wr_word] <= wr_data;
        end
    end

    // One cycle read latency
    always_ff @(posedge CLK) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// ==== hdl/mem_arbiter.sv ====
module mem_arbiter import matrix_pkg::*; (
    input  logic                  CLK,
    input  logic                  rst,
    input  logic                  req_a,
    input  logic [mem_addr_w-1:0] addr_a,
    output logic                  gnt_a,
    output logic                  rvalid_a,
    input  logic                  req_b,
    input  logic [mem_addr_w-1:0] addr_b,
    output logic                  gnt_b,
    output logic                  rvalid_b,
    output logic [elem_w-1:0]     rdata,
    output logic                  mem_rd_en,
    output logic [mem_addr_w-1:0] mem_rd_addr,
    input  logic [elem_w-1:0]     mem_rdata
);

    logic last_b;     // Port b had the most recent grant
    logic rd_pend;    // Read issued last cycle
    logic owner_b;    // Which port that read belongs to

    // On a tie the port not served last wins
    assign gnt_a = req_a && (!req_b || last_b);
    assign gnt_b = req_b && !gnt_a;

    assign mem_rd_en   = gnt_a || gnt_b;
    assign mem_rd_addr = gnt_b ? addr_b : addr_a;

    always_ff @(posedge CLK) begin
        if (rst) begin
            last_b  <= 1'b0;
            rd_pend <= 1'b0;
            owner_b <= 1'b0;
        end else begin
            rd_pend <= mem_rd_en;
            owner_b <= gnt_b;
            if (gnt_a) begin
                last_b <= 1'b0;
            end else if (gnt_b) begin
                last_b <= 1'b1;
            end
        end
    end

    // Steer the returning word to the port granted a cycle ago
    assign rvalid_a = rd_pend && !owner_b;
    assign rvalid_b = rd_pend && owner_b;
    assign rdata    = mem_rdata;                 // Shared, qualified by rvalid

    // Tie goes to b when a was served in the previous cycle
    a_rr_to_b: assert property (@(posedge CLK) disable iff (rst)
        req_a && req_b && $past(gnt_a) |-> gnt_b);

    a_rr_to_a: assert property (@(posedge CLK) disable iff (rst)
        req_a && req_b && $past(gnt_b) |-> gnt_a);

endmodule

// ==== hdl/matrix_fetch.sv ====
module matrix_fetch import matrix_pkg::*; (
    input  logic                  CLK,
    input  logic                  rst,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  logic                  multi,
    input  logic                  vertical,
    input  matrix_addr_u          address,
    output logic                  done,
    output logic [result_w-1:0]   data,
    output logic                  mem_req,
    output logic [mem_addr_w-1:0] mem_addr,
    input  logic                  mem_gnt,
    input  logic                  mem_rvalid,
    input  logic [elem_w-1:0]     mem_rdata
);

    logic                 busy;
    logic                 accept;
    logic                 issue;
    logic                 multi_q;
    logic                 vertical_q;
    logic [mat_idx_w-1:0] row_q;
    logic [mat_idx_w-1:0] col_q;
    logic [1:0]           issue_cnt;   // Reads granted so far
    logic [1:0]           ret_cnt;     // Reads returned so far
    logic [1:0]           last_idx;

    assign req_ready = !busy;
    assign accept    = req_valid && req_ready;
    assign issue     = mem_req && mem_gnt;
    assign mem_addr  = {row_q, col_q};

    // Index of the final read for this request
    assign last_idx = (multi_q == mode_multi) ? 2'(multi_count - 1) : 2'd0;

    always_ff @(posedge CLK) begin
        if (rst) begin
            busy      <= 1'b0;
            mem_req   <= 1'b0;
            done      <= 1'b0;
            issue_cnt <= 2'd0;
            ret_cnt   <= 2'd0;
        end else begin
            done <= 1'b0;
            if (accept) begin
                busy      <= 1'b1;
                mem_req   <= 1'b1;         // First read goes out next cycle
                issue_cnt <= 2'd0;
                ret_cnt   <= 2'd0;
            end
            if (issue) begin
                issue_cnt <= issue_cnt + 2'd1;
                if (issue_cnt == last_idx) begin
                    mem_req <= 1'b0;
                end
            end
            if (mem_rvalid) begin
                ret_cnt <= ret_cnt + 2'd1;
                if (ret_cnt == last_idx) begin
                    done <= 1'b1;
                    busy <= 1'b0;
                end
            end
        end
    end

    // Request capture and address walk
    always_ff @(posedge CLK) begin
        if (accept) begin
            multi_q    <= multi;
            vertical_q <= vertical;
            row_q      <= address.rc.row[mat_idx_w-1:0];
            col_q      <= address.rc.col[mat_idx_w-1:0];
        end else if (issue) begin
            // Index wraps modulo the matrix size
            case (vertical_q)
                dir_horiz: col_q <= col_q + 1'b1;
                dir_vert:  row_q <= row_q + 1'b1;
                default:   col_q <= col_q;
            endcase
        end
    end

    // Result assembly
    always_ff @(posedge CLK) begin
        if (mem_rvalid) begin
            case (multi_q)
                mode_single: data <= {{(result_w - elem_w){mem_rdata[elem_w-1]}}, mem_rdata};
                mode_multi:  data[ret_cnt*elem_w +: elem_w] <= mem_rdata;  // First in low bits
                default:     data <= data;
            endcase
        end
    end

    // Address held until the arbiter takes it
    a_addr_stable: assert property (@(posedge CLK) disable iff (rst)
        mem_req && !mem_gnt |=> $stable(mem_addr));

    // Read data only comes back for a live request
    a_no_stray_rvalid: assert property (@(posedge CLK) disable iff (rst)
        mem_rvalid |-> busy);

endmodule

// ==== hdl/matrix_fetch_top.sv ====
module matrix_fetch_top import matrix_pkg::*; (
    input  logic                CLK,
    input  logic                rst,
    input  logic                a_req_valid,
    output logic                a_req_ready,
    input  logic                a_multi,
    input  logic                a_vertical,
    input  logic [31:0]         a_address,
    output logic                a_done,
    output logic [result_w-1:0] a_data,
    input  logic                b_req_valid,
    output logic                b_req_ready,
    input  logic                b_multi,
    input  logic                b_vertical,
    input  logic [31:0]         b_address,
    output logic                b_done,
    output logic [result_w-1:0] b_data,
    input  logic                load_en,
    input  logic [31:0]         load_address,
    input  logic [elem_w-1:0]   load_data
);

    matrix_addr_u          a_addr_u;
    matrix_addr_u          b_addr_u;
    matrix_addr_u          load_addr_u;

    logic                  a_mem_req, a_mem_gnt, a_mem_rvalid;
    logic                  b_mem_req, b_mem_gnt, b_mem_rvalid;
    logic [mem_addr_w-1:0] a_mem_addr;
    logic [mem_addr_w-1:0] b_mem_addr;
    logic [elem_w-1:0]     rd_data_shared;  // Arbiter output to both units
    logic                  mem_rd_en;
    logic [mem_addr_w-1:0] mem_rd_addr;
    logic [elem_w-1:0]     mem_rd_data;

    assign a_addr_u.word    = a_address;
    assign b_addr_u.word    = b_address;
    assign load_addr_u.word = load_address;

    matrix_fetch fetch_a (
        .CLK(CLK), .rst(rst),
        .req_valid(a_req_valid), .req_ready(a_req_ready),
        .multi(a_multi), .vertical(a_vertical), .address(a_addr_u),
        .done(a_done), .data(a_data),
        .mem_req(a_mem_req), .mem_addr(a_mem_addr), .mem_gnt(a_mem_gnt),
        .mem_rvalid(a_mem_rvalid), .mem_rdata(rd_data_shared)
    );

    matrix_fetch fetch_b (
        .CLK(CLK), .rst(rst),
        .req_valid(b_req_valid), .req_ready(b_req_ready),
        .multi(b_multi), .vertical(b_vertical), .address(b_addr_u),
        .done(b_done), .data(b_data),
        .mem_req(b_mem_req), .mem_addr(b_mem_addr), .mem_gnt(b_mem_gnt),
        .mem_rvalid(b_mem_rvalid), .mem_rdata(rd_data_shared)
    );

    mem_arbiter arbiter (
        .CLK(CLK), .rst(rst),
        .req_a(a_mem_req), .addr_a(a_mem_addr), .gnt_a(a_mem_gnt), .rvalid_a(a_mem_rvalid),
        .req_b(b_mem_req), .addr_b(b_mem_addr), .gnt_b(b_mem_gnt), .rvalid_b(b_mem_rvalid),
        .rdata(rd_data_shared),
        .mem_rd_en(mem_rd_en), .mem_rd_addr(mem_rd_addr), .mem_rdata(mem_rd_data)
    );

    matrix_mem mem (
        .CLK(CLK),
        .wr_en(load_en), .wr_addr(load_addr_u), .wr_data(load_data),
        .rd_en(mem_rd_en), .rd_addr(mem_rd_addr), .rd_data(mem_rd_data)
    );

endmodule

// ==== test/matrix_fetch_tb.sv ====
module matrix_fetch_tb import matrix_pkg::*; ();

    localparam int drive_dly      = 2;
    localparam int timeout_cycles = 60;

    logic                CLK;
    logic                rst;
    logic                a_req_valid;
    logic                a_req_ready;
    logic                a_multi;
    logic                a_vertical;
    logic [31:0]         a_address;
    logic                a_done;
    logic [result_w-1:0] a_data;
    logic                b_req_valid;
    logic                b_req_ready;
    logic                b_multi;
    logic                b_vertical;
    logic [31:0]         b_address;
    logic                b_done;
    logic [result_w-1:0] b_data;
    logic                load_en;
    logic [31:0]         load_address;
    logic [elem_w-1:0]   load_data;

    // Request groups from one test line, index 0 then 1
    logic                gm [2];
    logic                gv [2];
    logic [15:0]         gr [2];
    logic [15:0]         gc [2];
    logic [result_w-1:0] ge [2];

    int test_err;
    int pass_count;
    int fail_count;
    int seed = 32'h3cf8_0e74;

    matrix_fetch_top matrix_fetch_top_i (.*);

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    function automatic string port_name(input int p);
        return (p == 0) ? "a" : "b";
    endfunction

    function automatic logic port_ready(input int p);
        return (p == 0) ? a_req_ready : b_req_ready;
    endfunction

    function automatic logic port_done(input int p);
        return (p == 0) ? a_done : b_done;
    endfunction

    function automatic logic [result_w-1:0] port_data(input int p);
        return (p == 0) ? a_data : b_data;
    endfunction

    task automatic drive_group(input int p, input logic valid, input int g);
        if (p == 0) begin
            a_req_valid = valid;
            a_multi     = gm[g];
            a_vertical  = gv[g];
            a_address   = {gr[g], gc[g]};
        end else begin
            b_req_valid = valid;
            b_multi     = gm[g];
            b_vertical  = gv[g];
            b_address   = {gr[g], gc[g]};
        end
    endtask

    task automatic apply_load(input logic [15:0] row, input logic [15:0] col,
                              input logic [elem_w-1:0] value);
        @(posedge CLK);
        #drive_dly;
        load_en      = 1'b1;
        load_address = {row, col};
        load_data    = value;
        @(posedge CLK);
        #drive_dly;
        load_en = 1'b0;
    endtask

    // Returns just after the accepting edge
    task automatic wait_accept(input int p, output bit ok);
        int cycles;
        cycles = 0;
        ok     = 1'b0;
        while (!ok && cycles < timeout_cycles) begin
            if (port_ready(p)) begin
                ok = 1'b1;
            end else begin
                @(negedge CLK);
                cycles++;
            end
        end
        if (ok) begin
            @(posedge CLK);
            #drive_dly;
        end else begin
            $display("Timeout: port %s never accepted a request", port_name(p));
            test_err++;
        end
    endtask

    task automatic wait_result(input int p, input logic [result_w-1:0] exp);
        int                  cycles;
        logic                seen;
        logic                early;
        logic [result_w-1:0] got;
        cycles = 0;
        seen   = 1'b0;
        early  = 1'b0;
        while (!seen && cycles < timeout_cycles) begin
            @(negedge CLK);
            cycles++;
            if (port_done(p)) begin
                seen = 1'b1;
            end else if (port_ready(p) && !early) begin
                $display("Port %s was ready again before its done pulse", port_name(p));
                early = 1'b1;
                test_err++;
            end
        end
        if (!seen) begin
            $display("Timeout: port %s never finished", port_name(p));
            test_err++;
        end else begin
            got = port_data(p);
            if (got !== exp) begin
                $display("FAIL %s_data expected %h got %h", port_name(p), exp, got);
                test_err++;
            end
        end
    endtask

    task automatic run_request(input int p, input int g);
        bit ok;
        @(posedge CLK);
        #drive_dly;
        drive_group(p, 1'b1, g);
        wait_accept(p, ok);
        drive_group(p, 1'b0, g);
        if (ok) begin
            wait_result(p, ge[g]);
        end
    endtask

    // Second request stays valid while the first one is in flight
    task automatic run_queued(input int p);
        bit ok;
        @(posedge CLK);
        #drive_dly;
        drive_group(p, 1'b1, 0);
        wait_accept(p, ok);
        if (ok) begin
            drive_group(p, 1'b1, 1);
            wait_result(p, ge[0]);
            wait_accept(p, ok);
        end
        drive_group(p, 1'b0, 1);
        if (ok) begin
            wait_result(p, ge[1]);
        end
    endtask

    initial begin
        int                fd;
        int                n;
        int                num;
        int                groups;
        int                gap;
        string             kind;
        string             port;
        string             rest;
        logic [15:0]       lrow;
        logic [15:0]       lcol;
        logic [elem_w-1:0] lval;
        rst          = 1'b1;
        a_req_valid  = 1'b0;
        a_multi      = 1'b0;
        a_vertical   = 1'b0;
        a_address    = '0;
        b_req_valid  = 1'b0;
        b_multi      = 1'b0;
        b_vertical   = 1'b0;
        b_address    = '0;
        load_en      = 1'b0;
        load_address = '0;
        load_data    = '0;
        pass_count   = 0;
        fail_count   = 0;
        repeat (4) @(posedge CLK);
        #drive_dly;
        rst = 1'b0;

        fd = $fopen("test/matrix_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test vector file");
            fail_count++;
        end else begin
            while ($fscanf(fd, "%s", kind) == 1) begin
                if (kind == "#") begin
                    n = $fgets(rest, fd);              // Rest of a comment line
                end else if (kind == "L") begin
                    n = $fscanf(fd, "%d %d %h", lrow, lcol, lval);
                    apply_load(lrow, lcol, lval);
                end else if (kind == "F" || kind == "Q") begin
                    n        = $fscanf(fd, "%d %s", num, port);
                    groups   = (port == "both" || kind == "Q") ? 2 : 1;
                    test_err = 0;
                    for (int g = 0; g < groups; g++) begin
                        n = $fscanf(fd, "%d %d %d %d %h", gm[g], gv[g], gr[g], gc[g], ge[g]);
                        if (n != 5) begin
                            $display("Test %0d has a malformed request group", num);
                            test_err++;
                        end
                    end
                    gap = $unsigned($random(seed)) % 4;  // Idle cycles before the test
                    repeat (gap) @(posedge CLK);
                    if (test_err != 0) begin
                        // Nothing to run
                    end else if (kind == "Q") begin
                        run_queued((port == "b") ? 1 : 0);
                    end else if (port == "both") begin
                        fork
                            run_request(0, 0);
                            run_request(1, 1);
                        join
                    end else begin
                        run_request((port == "b") ? 1 : 0, 0);
                    end
                    if (test_err == 0) begin
                        pass_count++;
                        $display("Test %0d passed", num);
                    end else begin
                        fail_count++;
                        $display("Test %0d did not pass", num);
                    end
                end else begin
                    $display("Unknown line kind %s in the test vector file", kind);
                    fail_count++;
                end
            end
            $fclose(fd);
        end

        $display("Tests passed: %0d, tests with errors: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== test/matrix_tests.txt ====
# L row col value(hex)
# F|Q test port then per port: multi vertical row col expected(hex); Q queues two on one port
L 2 5 8001
L 2 6 1234
L 2 7 7fff
L 4 9 0a0a
L 5 9 b00b
L 6 9 0c0c
L 7 14 1111
L 7 15 2222
L 7 0 3333
L 15 3 f003
L 0 3 0003
L 1 3 1003
F 1 a 0 0 2 5 ffffffff8001
F 2 b 0 0 2 6 000000001234
F 3 b 0 1 2 5 ffffffff8001
F 4 a 1 0 2 5 7fff12348001
F 5 b 1 0 2 5 7fff12348001
F 6 a 1 1 4 9 0c0cb00b0a0a
F 7 b 1 1 4 9 0c0cb00b0a0a
F 8 a 1 0 7 14 333322221111
F 9 b 1 1 15 3 10030003f003
F 10 both 1 0 2 5 7fff12348001 0 0 15 3 fffffffff003
F 11 both 1 1 15 3 10030003f003 1 0 7 14 333322221111
F 12 both 0 0 2 7 000000007fff 0 0 2 7 000000007fff
F 13 both 1 0 7 14 333322221111 1 1 4 9 0c0cb00b0a0a
Q 14 b 0 0 2 7 000000007fff 1 1 4 9 0c0cb00b0a0a
Q 15 a 1 0 2 5 7fff12348001 0 0 15 3 fffffffff003

// ==== src.f ====
hdl/matrix_pkg.sv
hdl/matrix_mem.sv
hdl/mem_arbiter.sv
hdl/matrix_fetch.sv
hdl/matrix_fetch_top.sv
test/matrix_fetch_tb.sv

// ==== Makefile ====
TOP = matrix_fetch_tb
LOG = sim.log

all: run

obj_dir/V$(TOP): src.f $(shell cat src.f) test/matrix_tests.txt
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

lint:
	verilator --lint-only --timing -f src.f --top-module $(TOP)
	verilator --lint-only hdl/matrix_pkg.sv hdl/matrix_mem.sv hdl/mem_arbiter.sv \
		hdl/matrix_fetch.sv hdl/matrix_fetch_top.sv --top-module matrix_fetch_top

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all run lint clean
